//--- csr_pkg.sv
// shared CSR types; only the trap, timer and scratch addresses exist, TLB and DMW CSRs are absent
package csr_pkg;

    // ==============================
    // basic field types
    // ==============================
    typedef logic [13:0] csr_addr_t;
    typedef logic [31:0] csr_data_t;
    typedef logic [1:0]  plv_t;
    typedef logic [5:0]  ecode_t;
    typedef logic [8:0]  esubcode_t;
    typedef logic [7:0]  hw_int_t;

    typedef enum csr_addr_t {
        CRMD   = 14'h000,
        PRMD   = 14'h001,
        ECFG   = 14'h004,
        ESTAT  = 14'h005,
        ERA    = 14'h006,
        EENTRY = 14'h00c,
        SAVE0  = 14'h030,
        SAVE1  = 14'h031,
        SAVE2  = 14'h032,
        SAVE3  = 14'h033,
        TID    = 14'h040,
        TCFG   = 14'h041,
        TVAL   = 14'h042,
        TICLR  = 14'h044
    } csr_addr_e;

    // ==============================
    // field positions (lsb)
    // ==============================
    localparam int PLV       = 0;
    localparam int IE        = 2;
    localparam int DA        = 3;
    localparam int PPLV      = 0;
    localparam int PIE       = 2;
    localparam int IS        = 0;
    localparam int IS_W      = 13;
    localparam int TI        = 11;
    localparam int ECODE     = 16;
    localparam int ESUBCODE  = 22;
    localparam int EENTRY_VA = 6;
    localparam int EN        = 0;
    localparam int PERIODIC  = 1;
    localparam int INITVAL   = 2;
    localparam int CLR       = 0;

    // bit 10 of LIE is reserved
    localparam logic [IS_W-1:0] LIE_MASK = 13'h1bff;

    // ==============================
    // port structs
    // ==============================
    typedef struct packed {
        logic      en;
        csr_addr_t addr;
        csr_data_t data;
    } csr_wr_t;

    typedef struct packed {
        logic       crmd;
        logic       prmd;
        logic       ecfg;
        logic       estat;
        logic       era;
        logic       eentry;
        logic [3:0] save;
        logic       tid;
        logic       tcfg;
        logic       ticlr;
    } csr_wen_t;

    typedef struct packed {
        logic      excp_flush;
        logic      ertn_flush;
        csr_data_t era;
        ecode_t    ecode;
        esubcode_t esubcode;
    } trap_t;

endpackage

//--- csr_decode.sv
// write decode; TVAL is read-only and unmapped addresses raise no enable
module csr_decode import csr_pkg::*; (
    input  csr_wr_t  wr,
    output csr_wen_t wen
);

    always_comb begin
        wen = '0;
        if (wr.en) begin
            case (wr.addr)
                CRMD:    wen.crmd    = 1'b1;
                PRMD:    wen.prmd    = 1'b1;
                ECFG:    wen.ecfg    = 1'b1;
                ESTAT:   wen.estat   = 1'b1;
                ERA:     wen.era     = 1'b1;
                EENTRY:  wen.eentry  = 1'b1;
                SAVE0:   wen.save[0] = 1'b1;
                SAVE1:   wen.save[1] = 1'b1;
                SAVE2:   wen.save[2] = 1'b1;
                SAVE3:   wen.save[3] = 1'b1;
                TID:     wen.tid     = 1'b1;
                TCFG:    wen.tcfg    = 1'b1;
                TICLR:   wen.ticlr   = 1'b1;
                default: wen         = '0;
            endcase
        end
    end

endmodule

//--- csr_trap_regs.sv
// excp_flush and ertn_flush must never be high together; a flush overrides a same-cycle write
module csr_trap_regs import csr_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  csr_data_t wr_data,
    input  csr_wen_t  wen,
    input  trap_t     trap,
    input  hw_int_t   interrupt,
    input  logic      timer_int,
    output csr_data_t crmd,
    output csr_data_t prmd,
    output csr_data_t ecfg,
    output csr_data_t estat,
    output csr_data_t era,
    output csr_data_t eentry,
    output plv_t      plv,
    output logic      has_int
);

    plv_t                crmd_plv;
    logic                crmd_ie;
    logic                crmd_da;
    plv_t                prmd_pplv;
    logic                prmd_pie;
    logic [IS_W-1:0]     ecfg_lie;
    logic [1:0]          estat_swi;
    hw_int_t             estat_hwi;
    ecode_t              estat_ecode;
    esubcode_t           estat_esubcode;
    logic [31:EENTRY_VA] eentry_va;
    logic [IS_W-1:0]     is;

    // ==============================
    // crmd / prmd
    // ==============================
    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
            crmd_da  <= 1'b1;
        end else if (trap.excp_flush) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (trap.ertn_flush) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (wen.crmd) begin
            crmd_plv <= wr_data[PLV +: $bits(plv_t)];
            crmd_ie  <= wr_data[IE];
            crmd_da  <= wr_data[DA];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            prmd_pplv <= '0;
            prmd_pie  <= 1'b0;
        end else if (trap.excp_flush) begin
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
        end else if (wen.prmd) begin
            prmd_pplv <= wr_data[PPLV +: $bits(plv_t)];
            prmd_pie  <= wr_data[PIE];
        end
    end

    // ==============================
    // ecfg / estat
    // ==============================
    always_ff @(posedge clk) begin
        if (reset) begin
            ecfg_lie <= '0;
        end else if (wen.ecfg) begin
            ecfg_lie <= wr_data[IS +: IS_W] & LIE_MASK;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            estat_swi      <= '0;
            estat_hwi      <= '0;
            estat_ecode    <= '0;
            estat_esubcode <= '0;
        end else begin
            // hw lines sampled every cycle
            estat_hwi <= interrupt;
            if (wen.estat) begin
                estat_swi <= wr_data[IS +: 2];
            end
            if (trap.excp_flush) begin
                estat_ecode    <= trap.ecode;
                estat_esubcode <= trap.esubcode;
            end
        end
    end

    // ==============================
    // era / eentry
    // ==============================
    always_ff @(posedge clk) begin
        if (trap.excp_flush) begin
            era <= trap.era;
        end else if (wen.era) begin
            era <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (wen.eentry) begin
            eentry_va <= wr_data[31:EENTRY_VA];
        end
    end

    // bit 12 (ipi) and bit 10 stay zero
    always_comb begin
        is          = '0;
        is[1:0]     = estat_swi;
        is[9:2]     = estat_hwi;
        is[TI - IS] = timer_int;
    end

    always_comb begin
        crmd                        = '0;
        crmd[PLV +: $bits(plv_t)]   = crmd_plv;
        crmd[IE]                    = crmd_ie;
        crmd[DA]                    = crmd_da;
        prmd                        = '0;
        prmd[PPLV +: $bits(plv_t)]  = prmd_pplv;
        prmd[PIE]                   = prmd_pie;
        ecfg                        = '0;
        ecfg[IS +: IS_W]            = ecfg_lie;
        estat                       = '0;
        estat[IS +: IS_W]           = is;
        estat[ECODE +: $bits(ecode_t)]       = estat_ecode;
        estat[ESUBCODE +: $bits(esubcode_t)] = estat_esubcode;
        eentry                      = '0;
        eentry[31:EENTRY_VA]        = eentry_va;
    end

    assign plv     = crmd_plv;
    assign has_int = (|(ecfg_lie & is)) & crmd_ie;

endmodule

//--- csr_timer.sv
// TIMER_WIDTH between 3 and 32; TVAL is read-only and counts down only while TCFG.EN is set
module csr_timer import csr_pkg::*; #(
    parameter int TIMER_WIDTH = 32
) (
    input  logic      clk,
    input  logic      reset,
    input  csr_data_t wr_data,
    input  csr_wen_t  wen,
    output csr_data_t tcfg,
    output csr_data_t tval,
    output logic      timer_int
);

    logic                   en;
    logic                   periodic;
    logic [TIMER_WIDTH-3:0] initval;
    logic [TIMER_WIDTH-1:0] count;
    logic                   expire;

    assign expire = en && (count == '0);

    // ==============================
    // tcfg fields and enable
    // ==============================
    always_ff @(posedge clk) begin
        if (reset) begin
            en       <= 1'b0;
            periodic <= 1'b0;
            initval  <= '0;
        end else if (wen.tcfg) begin
            en       <= wr_data[EN];
            periodic <= wr_data[PERIODIC];
            initval  <= wr_data[INITVAL +: TIMER_WIDTH-2];
        end else if (expire) begin
            // one-shot stops here
            en <= periodic;
        end
    end

    // down-counter
    always_ff @(posedge clk) begin
        if (wen.tcfg) begin
            count <= {wr_data[INITVAL +: TIMER_WIDTH-2], 2'b00};
        end else if (expire) begin
            count <= periodic ? {initval, 2'b00} : '1;
        end else if (en) begin
            count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            timer_int <= 1'b0;
        end else if (wen.ticlr && wr_data[CLR]) begin
            timer_int <= 1'b0;
        end else if (expire) begin
            timer_int <= 1'b1;
        end
    end

    always_comb begin
        tcfg                              = '0;
        tcfg[EN]                          = en;
        tcfg[PERIODIC]                    = periodic;
        tcfg[INITVAL +: TIMER_WIDTH-2]    = initval;
        tval                              = '0;
        tval[TIMER_WIDTH-1:0]             = count;
    end

endmodule

//--- csr_scratch_regs.sv
// SAVE0 to SAVE3 hold undefined values until first written
module csr_scratch_regs import csr_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  csr_data_t       wr_data,
    input  csr_wen_t        wen,
    output csr_data_t [3:0] save,
    output csr_data_t       tid
);

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (wen.save[i]) begin
                save[i] <= wr_data;
            end
        end
    end

    // timer id
    always_ff @(posedge clk) begin
        if (reset) begin
            tid <= '0;
        end else if (wen.tid) begin
            tid <= wr_data;
        end
    end

endmodule

//--- csr_read_mux.sv
// combinational read; unmapped addresses and TICLR return zero
module csr_read_mux import csr_pkg::*; #(
    parameter int TIMER_WIDTH = 32
) (
    input  csr_addr_t       rd_addr,
    input  csr_data_t       crmd,
    input  csr_data_t       prmd,
    input  csr_data_t       ecfg,
    input  csr_data_t       estat,
    input  csr_data_t       era,
    input  csr_data_t       eentry,
    input  csr_data_t [3:0] save,
    input  csr_data_t       tid,
    input  csr_data_t       tcfg,
    input  csr_data_t       tval,
    output csr_data_t       rd_data
);

    csr_data_t tval_rd;

    // only the implemented counter bits
    always_comb begin
        tval_rd                        = '0;
        tval_rd[TIMER_WIDTH-1:0]       = tval[TIMER_WIDTH-1:0];
    end

    always_comb begin
        case (rd_addr)
            CRMD:    rd_data = crmd;
            PRMD:    rd_data = prmd;
            ECFG:    rd_data = ecfg;
            ESTAT:   rd_data = estat;
            ERA:     rd_data = era;
            EENTRY:  rd_data = eentry;
            SAVE0:   rd_data = save[0];
            SAVE1:   rd_data = save[1];
            SAVE2:   rd_data = save[2];
            SAVE3:   rd_data = save[3];
            TID:     rd_data = tid;
            TCFG:    rd_data = tcfg;
            TVAL:    rd_data = tval_rd;
            TICLR:   rd_data = '0;
            default: rd_data = '0;
        endcase
    end

endmodule

//--- csr_file.sv
// writes are single-cycle strobes with no handshake; plv follows a flush one cycle later
module csr_file import csr_pkg::*; #(
    parameter int TIMER_WIDTH = 32
) (
    input  logic      clk,
    input  logic      reset,
    input  csr_wr_t   wr,
    input  csr_addr_t rd_addr,
    input  trap_t     trap,
    input  hw_int_t   interrupt,
    output csr_data_t rd_data,
    output logic      has_int,
    output plv_t      plv,
    output csr_data_t eentry,
    output csr_data_t era
);

    csr_wen_t        wen;
    csr_data_t       crmd;
    csr_data_t       prmd;
    csr_data_t       ecfg;
    csr_data_t       estat;
    csr_data_t       tcfg;
    csr_data_t       tval;
    csr_data_t [3:0] save;
    csr_data_t       tid;
    logic            timer_int;

    // ==============================
    // decode
    // ==============================
    csr_decode csr_decode_i (
        .wr  (wr),
        .wen (wen)
    );

    // ==============================
    // register banks
    // ==============================
    csr_trap_regs csr_trap_regs_i (
        .clk       (clk),
        .reset     (reset),
        .wr_data   (wr.data),
        .wen       (wen),
        .trap      (trap),
        .interrupt (interrupt),
        .timer_int (timer_int),
        .crmd      (crmd),
        .prmd      (prmd),
        .ecfg      (ecfg),
        .estat     (estat),
        .era       (era),
        .eentry    (eentry),
        .plv       (plv),
        .has_int   (has_int)
    );

    csr_timer #(
        .TIMER_WIDTH (TIMER_WIDTH)
    ) csr_timer_i (
        .clk       (clk),
        .reset     (reset),
        .wr_data   (wr.data),
        .wen       (wen),
        .tcfg      (tcfg),
        .tval      (tval),
        .timer_int (timer_int)
    );

    csr_scratch_regs csr_scratch_regs_i (
        .clk     (clk),
        .reset   (reset),
        .wr_data (wr.data),
        .wen     (wen),
        .save    (save),
        .tid     (tid)
    );

    // read side
    csr_read_mux #(
        .TIMER_WIDTH (TIMER_WIDTH)
    ) csr_read_mux_i (
        .rd_addr (rd_addr),
        .crmd    (crmd),
        .prmd    (prmd),
        .ecfg    (ecfg),
        .estat   (estat),
        .era     (era),
        .eentry  (eentry),
        .save    (save),
        .tid     (tid),
        .tcfg    (tcfg),
        .tval    (tval),
        .rd_data (rd_data)
    );

endmodule

//--- csr_checker.sv
// assertions bound into every csr_file instance; silent while reset is high
module csr_checker import csr_pkg::*; (
    input logic      clk,
    input logic      reset,
    input csr_wr_t   wr,
    input trap_t     trap,
    input plv_t      plv,
    input logic      has_int,
    input csr_addr_t rd_addr,
    input csr_data_t rd_data
);

    timeunit 1ns;
    timeprecision 1ps;

    logic mapped;

    assign mapped = rd_addr inside {CRMD, PRMD, ECFG, ESTAT, ERA, EENTRY,
                                    SAVE0, SAVE1, SAVE2, SAVE3, TID, TCFG, TVAL, TICLR};

    // clearing IE masks any pending request
    ie_clear_masks_int: assert property (@(posedge clk) disable iff (reset)
        wr.en && wr.addr == CRMD && !wr.data[IE] && !trap.ertn_flush |=> !has_int)
        else $error("has_int still high after a CRMD write cleared IE");

    excp_clears_plv: assert property (@(posedge clk) disable iff (reset)
        trap.excp_flush |=> plv == '0)
        else $error("plv not zero one cycle after excp_flush");

    unmapped_reads_zero: assert property (@(posedge clk) disable iff (reset)
        !mapped |-> rd_data == '0)
        else $error("unmapped address returned nonzero read data");

endmodule

bind csr_file csr_checker csr_checker_i (
    .clk     (clk),
    .reset   (reset),
    .wr      (wr),
    .trap    (trap),
    .plv     (plv),
    .has_int (has_int),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
);

//--- tb_csr_file.sv
// directed testbench for csr_file; assumes TIMER_WIDTH 32 and a timer period well above ten cycles
module tb_csr_file import csr_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMER_WIDTH = 32;
    localparam int UNMAPPED    = 14'h100;

    logic      clk = 1'b0;
    logic      reset;
    csr_wr_t   wr;
    csr_addr_t rd_addr;
    trap_t     trap;
    hw_int_t   interrupt;
    csr_data_t rd_data;
    logic      has_int;
    plv_t      plv;
    csr_data_t eentry;
    csr_data_t era;

    int checks   = 0;
    int errors   = 0;
    int timeouts = 0;

    always #10 clk = ~clk;

    csr_file #(
        .TIMER_WIDTH (TIMER_WIDTH)
    ) csr_file_i (
        .clk       (clk),
        .reset     (reset),
        .wr        (wr),
        .rd_addr   (rd_addr),
        .trap      (trap),
        .interrupt (interrupt),
        .rd_data   (rd_data),
        .has_int   (has_int),
        .plv       (plv),
        .eentry    (eentry),
        .era       (era)
    );

    // ==============================
    // bus helpers
    // ==============================
    task automatic write_csr(input csr_addr_t addr, input csr_data_t data);
        @(posedge clk);
        wr <= {1'b1, addr, data};
        @(posedge clk);
        wr.en <= 1'b0;
    endtask

    task automatic read_csr(input csr_addr_t addr, output csr_data_t data);
        @(posedge clk);
        rd_addr <= addr;
        @(negedge clk);
        data = rd_data;
    endtask

    task automatic check_value(input string what, input csr_data_t got, input csr_data_t exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAILED %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
        end
    endtask

    task automatic expect_csr(input string what, input csr_addr_t addr, input csr_data_t exp);
        csr_data_t got;
        read_csr(addr, got);
        check_value(what, got, exp);
    endtask

    // rd_addr must already point at ESTAT
    task automatic wait_timer_int(input int limit, output int cycles);
        bit seen;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles <= limit) begin
            @(negedge clk);
            if (rd_data[TI]) begin
                seen = 1'b1;
            end else begin
                @(posedge clk);
                cycles++;
            end
        end
        if (!seen) begin
            timeouts++;
            $display("timeout: timer interrupt did not rise within %0d cycles", limit);
            cycles = -1;
        end
    endtask

    // ==============================
    // tests
    // ==============================
    task automatic reset_values();
        expect_csr("CRMD after reset", CRMD, 32'h8);
        expect_csr("ECFG after reset", ECFG, 32'h0);
        expect_csr("ESTAT after reset", ESTAT, 32'h0);
        expect_csr("TCFG after reset", TCFG, 32'h0);
        expect_csr("TID after reset", TID, 32'h0);
        check_value("has_int after reset", 32'(has_int), 32'h0);
        check_value("plv after reset", 32'(plv), 32'h0);
    endtask

    task automatic scratch_and_masked();
        csr_data_t vals [7];
        csr_addr_t addrs [5];
        addrs = '{SAVE0, SAVE1, SAVE2, SAVE3, TID};
        foreach (vals[i]) begin
            vals[i] = $urandom;
        end
        foreach (addrs[i]) begin
            write_csr(addrs[i], vals[i]);
        end
        write_csr(EENTRY, vals[5]);
        write_csr(ECFG, vals[6]);
        foreach (addrs[i]) begin
            expect_csr($sformatf("scratch 0x%03h", addrs[i]), addrs[i], vals[i]);
        end
        expect_csr("EENTRY", EENTRY, vals[5] & ~32'h3f);
        check_value("eentry output", eentry, vals[5] & ~32'h3f);
        expect_csr("ECFG", ECFG, vals[6] & 32'h1bff);
        expect_csr("unmapped address", UNMAPPED, 32'h0);
        write_csr(ECFG, 32'h0);
    endtask

    task automatic trap_entry_return();
        csr_data_t epc;
        ecode_t    code;
        esubcode_t sub;
        epc  = $urandom;
        code = ecode_t'($urandom);
        sub  = esubcode_t'($urandom);
        write_csr(CRMD, 32'hf);
        @(posedge clk);
        trap <= {1'b1, 1'b0, epc, code, sub};
        @(posedge clk);
        trap.excp_flush <= 1'b0;
        @(negedge clk);
        check_value("plv after exception", 32'(plv), 32'h0);
        expect_csr("CRMD after exception", CRMD, 32'h8);
        expect_csr("PRMD after exception", PRMD, 32'h7);
        expect_csr("ERA after exception", ERA, epc);
        check_value("era output after exception", era, epc);
        expect_csr("ESTAT after exception", ESTAT, {1'b0, sub, code, 16'h0});
        @(posedge clk);
        trap.ertn_flush <= 1'b1;
        @(posedge clk);
        trap.ertn_flush <= 1'b0;
        expect_csr("CRMD after return", CRMD, 32'hf);
        check_value("plv after return", 32'(plv), 32'h3);
    endtask

    task automatic hardware_interrupt();
        int line;
        csr_data_t got;
        line = $urandom % 8;
        write_csr(ECFG, 32'h1 << (line + 2));
        write_csr(CRMD, 32'hc);
        @(posedge clk);
        interrupt <= hw_int_t'(1 << line);
        rd_addr   <= ESTAT;
        @(negedge clk);
        check_value("has_int before sampling", 32'(has_int), 32'h0);
        @(negedge clk);
        got = rd_data;
        check_value("ESTAT.IS with line raised", got[12:0], 13'h1 << (line + 2));
        check_value("has_int with line raised", 32'(has_int), 32'h1);
        write_csr(CRMD, 32'h8);
        @(negedge clk);
        check_value("has_int with IE clear", 32'(has_int), 32'h0);
        @(posedge clk);
        interrupt <= '0;
        write_csr(ECFG, 32'h0);
    endtask

    task automatic timer_modes();
        int n;
        int cycles;
        csr_data_t got;
        n = 3 + $urandom % 4;
        // one-shot
        @(posedge clk);
        rd_addr <= ESTAT;
        write_csr(TCFG, (n << 2) | 32'h1);
        wait_timer_int(4 * n + 10, cycles);
        check_value("one-shot delay in cycles", cycles, 4 * n + 1);
        expect_csr("TVAL after one-shot", TVAL, 32'hffff_ffff);
        write_csr(TICLR, 32'h1);
        read_csr(ESTAT, got);
        check_value("TI after clear", 32'(got[TI]), 32'h0);
        // periodic
        write_csr(TCFG, (n << 2) | 32'h3);
        wait_timer_int(4 * n + 10, cycles);
        write_csr(TICLR, 32'h1);
        read_csr(ESTAT, got);
        check_value("TI after periodic clear", 32'(got[TI]), 32'h0);
        wait_timer_int(4 * n + 10, cycles);
        write_csr(TCFG, 32'h0);
        write_csr(TICLR, 32'h1);
    endtask

    initial begin
        void'($urandom(32'h61e1));
        reset     <= 1'b1;
        wr        <= '0;
        rd_addr   <= '0;
        trap      <= '0;
        interrupt <= '0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        reset_values();
        scratch_and_masked();
        trap_entry_return();
        hardware_interrupt();
        timer_modes();
        repeat (2) @(posedge clk);
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- all.f
csr_pkg.sv
csr_decode.sv
csr_trap_regs.sv
csr_timer.sv
csr_scratch_regs.sv
csr_read_mux.sv
csr_file.sv
csr_checker.sv
tb_csr_file.sv

//--- Bender.yml
package:
  name: csr_file

sources:
  - csr_pkg.sv
  - csr_decode.sv
  - csr_trap_regs.sv
  - csr_timer.sv
  - csr_scratch_regs.sv
  - csr_read_mux.sv
  - csr_file.sv
  - target: simulation
    files:
      - csr_checker.sv
      - tb_csr_file.sv
